// File: design/pmp_check_port.sv
// PMP check port
`default_nettype none

module pmp_check_port
    import pmp_pkg::*;
#(
    parameter int depth = 16
) (
    input  wire check_req_t req,
    input  wire pmp_cfg_t   cfg      [depth],
    input  wire [29:0]      addr_reg [depth],
    input  wire [29:0]      base     [depth],
    output check_rsp_t      rsp
);

    logic [depth-1:0] hit;
    logic [depth-1:0] apply;
    logic [depth-1:0] sel;

    for (genvar i = 0; i < depth; i++) begin : g_entry
        pmp_region_match u_match (
            .addr     (req.addr),
            .cfg      (cfg[i]),
            .addr_reg (addr_reg[i]),
            .base     (base[i]),
            .hit      (hit[i])
        );

        // Machine mode only sees locked entries.
        assign apply[i] = hit[i] && (!req.m_mode || cfg[i].lock);
    end

    // Lowest applying entry wins.
    assign sel = apply & (~apply + 1'b1);

    always_comb begin
        rsp = '0;
        if (apply == '0) begin
            // No entry applies, so fall back to the privilege default.
            rsp.r = req.m_mode;
            rsp.w = req.m_mode;
            rsp.x = req.m_mode;
        end else begin
            for (int i = 0; i < depth; i++) begin
                if (sel[i]) begin
                    rsp.r = cfg[i].r;
                    rsp.w = cfg[i].w;
                    rsp.x = cfg[i].x;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/pmp_csr_file.sv
// PMP CSR register file
`default_nettype none

module pmp_csr_file
    import pmp_pkg::*;
#(
    parameter int depth = 16
) (
    input  wire            clk,
    input  wire            rst,
    input  wire csr_req_t  csr_req,
    output csr_rsp_t       csr_rsp,
    output pmp_cfg_t       cfg      [depth],
    output logic [29:0]    addr_reg [depth],
    output logic [29:0]    base     [depth],
    output logic           locking
);

    localparam int          idx_w    = $clog2(depth);
    localparam logic [11:0] cfg_regs = 12'(depth / 4);

    // Offsets from the first CSR of each range.
    logic [11:0]      cfg_off;
    logic [11:0]      addr_off;
    logic             cfg_sel;
    logic             addr_sel;
    logic [idx_w-3:0] cfg_grp;
    logic [idx_w-1:0] addr_idx;

    logic [depth-1:0] writeable;
    pmp_cfg_t         wr_cfg  [4];
    logic [3:0]       cfg_wr_en;
    logic [3:0]       lock_set;
    logic             addr_wr_en;

    // Underflow wraps to a large offset, so one compare covers both bounds.
    assign cfg_off  = csr_req.num - csr_pmpcfg0;
    assign addr_off = csr_req.num - csr_pmpaddr0;
    assign cfg_sel  = cfg_off < cfg_regs;
    assign addr_sel = addr_off < 12'(depth);
    assign cfg_grp  = cfg_off[idx_w-3:0];
    assign addr_idx = addr_off[idx_w-1:0];

    // An entry below a locked TOR entry loses write access too.
    for (genvar i = 0; i < depth; i++) begin : g_wr
        if (i < depth - 1) begin : g_mid
            assign writeable[i] = !cfg[i].lock &&
                                  !(cfg[i+1].lock && cfg[i+1].mode == pmp_tor);
        end else begin : g_last
            assign writeable[i] = !cfg[i].lock;
        end
    end

    // Per-byte write enables for the selected configuration CSR.
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            wr_cfg[j]      = csr_req.wdata.cfg[j];
            wr_cfg[j].rsvd = '0;
            cfg_wr_en[j]   = csr_req.we && cfg_sel && writeable[{cfg_grp, 2'(j)}];
            lock_set[j]    = cfg_wr_en[j] && wr_cfg[j].lock;
        end
    end

    assign addr_wr_en = csr_req.we && addr_sel && writeable[addr_idx];
    assign locking    = |lock_set;

    // Register updates.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                cfg[i]      <= '0;
                addr_reg[i] <= '0;
            end
        end else begin
            for (int j = 0; j < 4; j++) begin
                if (cfg_wr_en[j]) begin
                    cfg[{cfg_grp, 2'(j)}] <= wr_cfg[j];
                end
            end
            if (addr_wr_en) begin
                addr_reg[addr_idx] <= csr_req.wdata.addr[29:0];
            end
        end
    end

    // Read port.
    always_comb begin
        csr_rsp = '0;
        if (cfg_sel) begin
            for (int j = 0; j < 4; j++) begin
                csr_rsp.rdata.cfg[j] = cfg[{cfg_grp, 2'(j)}];
            end
            csr_rsp.exists = 1'b1;
        end else if (addr_sel) begin
            // Grain is four bytes, so NAPOT words read back as stored.
            csr_rsp.rdata.addr = {2'b00, addr_reg[addr_idx]};
            csr_rsp.exists     = 1'b1;
        end
    end

    // TOR lower bound of each entry.
    assign base[0] = '0;
    for (genvar i = 1; i < depth; i++) begin : g_base
        assign base[i] = addr_reg[i-1];
    end

    // A locked entry holds its setup until reset.
    for (genvar i = 0; i < depth; i++) begin : g_lock_chk
        a_locked_stable: assert property (
            @(posedge clk) disable iff (rst)
            !rst && cfg[i].lock |=> $stable(cfg[i]) && $stable(addr_reg[i])
        ) else $error("locked PMP entry %0d changed", i);
    end

endmodule

`default_nettype wire

// File: design/pmp_pkg.sv
// PMP shared definitions
`default_nettype none

package pmp_pkg;

    // First configuration and first address CSR numbers.
    localparam logic [11:0] csr_pmpcfg0  = 12'h3a0;
    localparam logic [11:0] csr_pmpaddr0 = 12'h3b0;

    // Address matching modes.
    localparam logic [1:0] pmp_off   = 2'd0;
    localparam logic [1:0] pmp_tor   = 2'd1;
    localparam logic [1:0] pmp_na4   = 2'd2;
    localparam logic [1:0] pmp_napot = 2'd3;

    // One entry configuration byte, as laid out in pmpcfg.
    typedef struct packed {
        logic       lock;
        logic [1:0] rsvd;
        logic [1:0] mode;
        logic       x;
        logic       w;
        logic       r;
    } pmp_cfg_t;

    // CSR data word.
    // Configuration CSRs carry four bytes, address CSRs carry bits 33:2.
    typedef union packed {
        pmp_cfg_t [3:0] cfg;
        logic [31:0]    addr;
    } csr_word_u;

    // CSR access from the core.
    typedef struct packed {
        logic        we;
        logic [11:0] num;
        csr_word_u   wdata;
    } csr_req_t;

    // CSR read data back to the core.
    typedef struct packed {
        csr_word_u rdata;
        logic      exists;
    } csr_rsp_t;

    // Access to be checked, word address.
    typedef struct packed {
        logic [29:0] addr;
        logic        m_mode;
    } check_req_t;

    // Permission result of one check.
    typedef struct packed {
        logic r;
        logic w;
        logic x;
    } check_rsp_t;

endpackage

`default_nettype wire

// File: design/pmp_region_match.sv
// PMP region matcher
`default_nettype none

module pmp_region_match
    import pmp_pkg::*;
(
    input  wire [29:0]    addr,
    input  wire pmp_cfg_t cfg,
    input  wire [29:0]    addr_reg,
    input  wire [29:0]    base,
    output logic          hit
);

    // Trailing ones of the address register.
    logic [29:0] napot_mask;
    // Address bits the NAPOT compare ignores.
    logic [29:0] napot_ignore;

    // x & ~(x + 1) keeps only the run of trailing ones.
    assign napot_mask = addr_reg & ~(addr_reg + 30'd1);

    // k trailing ones leave k+1 low word bits free, 2^(k+3) bytes.
    assign napot_ignore = (napot_mask << 1) | 30'd1;

    always_comb begin
        hit = 1'b0;
        case (cfg.mode)
            pmp_off: begin
                hit = 1'b0;
            end
            pmp_tor: begin
                hit = (addr >= base) && (addr < addr_reg);
            end
            pmp_na4: begin
                hit = addr == addr_reg;
            end
            pmp_napot: begin
                hit = ((addr ^ addr_reg) & ~napot_ignore) == '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/pmp_unit.sv
// PMP unit top level
`default_nettype none

module pmp_unit
    import pmp_pkg::*;
#(
    parameter int depth    = 16,
    parameter int checkers = 2
) (
    input  wire             clk,
    input  wire             rst,
    input  wire csr_req_t   csr_req,
    output csr_rsp_t        csr_rsp,
    input  wire check_req_t check_req [checkers],
    output check_rsp_t      check_rsp [checkers],
    output logic            locking
);

    // Entry state shared by all check ports.
    pmp_cfg_t    cfg      [depth];
    logic [29:0] addr_reg [depth];
    logic [29:0] base     [depth];

    pmp_csr_file #(
        .depth (depth)
    ) u_csr_file (
        .clk      (clk),
        .rst      (rst),
        .csr_req  (csr_req),
        .csr_rsp  (csr_rsp),
        .cfg      (cfg),
        .addr_reg (addr_reg),
        .base     (base),
        .locking  (locking)
    );

    // One independent checker per access port.
    for (genvar p = 0; p < checkers; p++) begin : g_port
        pmp_check_port #(
            .depth (depth)
        ) u_check_port (
            .req      (check_req[p]),
            .cfg      (cfg),
            .addr_reg (addr_reg),
            .base     (base),
            .rsp      (check_rsp[p])
        );
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the PMP unit simulation with Verilator.
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module pmp_unit_tb -o pmp_sim
./obj_dir/pmp_sim > sim.log 2>&1 || true
cat sim.log
grep -q "TEST RESULT: PASS" sim.log

// File: verif/pmp_clock_gen.sv
// Testbench clock and reset
`default_nettype none

module pmp_clock_gen (
    output logic clk,
    output logic rst
);

    // Period of 20 time units.
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset spans the first two rising edges.
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #2 rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: verif/pmp_unit_tb.sv
// PMP unit testbench
`default_nettype none

module pmp_unit_tb
    import pmp_pkg::*;
();

    localparam int depth    = 16;
    localparam int checkers = 2;
    // Cycles per test, in run order.
    localparam int t_reset  = 24;
    localparam int t_rw     = 40;
    localparam int t_region = 150;
    localparam int t_prio   = 27;
    localparam int t_lock   = 32;
    localparam int t_mix    = 300;
    localparam int max_cycles =
        (2 + t_reset + t_rw + t_region + t_prio + t_lock + t_mix) * 6 / 5;
    // Around nested NA4, NAPOT and TOR regions.
    localparam logic [29:0] prio_addr [10] = '{30'h1233, 30'h1234, 30'h1235, 30'h1200,
        30'h123f, 30'h1240, 30'h127f, 30'h1280, 30'h1fff, 30'h2000};

    logic        clk;
    logic        rst;
    csr_req_t    csr_req;
    csr_rsp_t    csr_rsp;
    check_req_t  check_req [checkers];
    check_rsp_t  check_rsp [checkers];
    logic        locking;
    integer      seed;
    int          checks;
    int          errors;
    int          test_errors;
    int          cycles = 0;
    pmp_cfg_t    m_cfg  [depth];
    logic [29:0] m_addr [depth];
    logic [31:0] r;
    logic [11:0] num;
    csr_req_t    q;

    pmp_clock_gen u_clock_gen (.clk(clk), .rst(rst));

    pmp_unit #(.depth(depth), .checkers(checkers)) dut_i (
        .clk       (clk),
        .rst       (rst),
        .csr_req   (csr_req),
        .csr_rsp   (csr_rsp),
        .check_req (check_req),
        .check_rsp (check_rsp),
        .locking   (locking)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] rnd();
        rnd = $random(seed);
    endfunction

    // Register index of a CSR number, or -1 outside the range.
    function automatic int csr_index(input logic [11:0] n, input logic [11:0] first, input int k);
        csr_index = (n >= first && n < first + 12'(k)) ? int'(n - first) : -1;
    endfunction

    function automatic logic writeable(input int i);
        writeable = !m_cfg[i].lock;
        if (i < depth - 1) begin
            if (m_cfg[i+1].lock && m_cfg[i+1].mode == pmp_tor) writeable = 1'b0;
        end
    endfunction

    function automatic logic region_hit(input int i, input logic [29:0] a);
        logic [29:0] lo;
        int          k;
        lo = '0;
        if (i > 0) lo = m_addr[i-1];
        // NAPOT size from the run of trailing ones.
        k = 0;
        while (k < 30 && m_addr[i][k]) k++;
        case (m_cfg[i].mode)
            pmp_tor:   region_hit = a >= lo && a < m_addr[i];
            pmp_na4:   region_hit = a == m_addr[i];
            pmp_napot: region_hit = (a >> (k + 1)) == (m_addr[i] >> (k + 1));
            default:   region_hit = 1'b0;
        endcase
    endfunction

    function automatic check_rsp_t model_check(input logic [29:0] a, input logic mm);
        model_check = {mm, mm, mm};
        // Scan downward so the lowest applying entry decides.
        for (int i = depth - 1; i >= 0; i--) begin
            if (region_hit(i, a) && (!mm || m_cfg[i].lock)) begin
                model_check = {m_cfg[i].r, m_cfg[i].w, m_cfg[i].x};
            end
        end
    endfunction

    function automatic csr_rsp_t model_read(input logic [11:0] n);
        int c;
        int a;
        c = csr_index(n, csr_pmpcfg0, depth / 4);
        a = csr_index(n, csr_pmpaddr0, depth);
        model_read = '0;
        if (c >= 0) begin
            for (int j = 0; j < 4; j++) begin
                model_read.rdata.cfg[j] = m_cfg[c * 4 + j];
            end
        end else if (a >= 0) begin
            model_read.rdata.addr = {2'b00, m_addr[a]};
        end
        model_read.exists = c >= 0 || a >= 0;
    endfunction

    // Configuration bytes that a request would write.
    function automatic logic [3:0] cfg_writes(input csr_req_t w);
        int c;
        c = csr_index(w.num, csr_pmpcfg0, depth / 4);
        cfg_writes = '0;
        for (int j = 0; j < 4; j++) begin
            if (w.we && c >= 0) cfg_writes[j] = writeable(c * 4 + j);
        end
    endfunction

    function automatic void model_write(input csr_req_t w);
        logic [3:0] ok;
        int         c;
        int         a;
        ok = cfg_writes(w);
        c  = csr_index(w.num, csr_pmpcfg0, depth / 4);
        a  = csr_index(w.num, csr_pmpaddr0, depth);
        // Reserved bits are dropped.
        for (int j = 0; j < 4; j++) begin
            if (ok[j]) m_cfg[c * 4 + j] = w.wdata.cfg[j] & 8'h9f;
        end
        if (w.we && a >= 0) begin
            if (writeable(a)) m_addr[a] = w.wdata.addr[29:0];
        end
    endfunction

    function automatic csr_req_t csr_op(input logic we, input logic [11:0] n, input logic [31:0] d);
        csr_op.we         = we;
        csr_op.num        = n;
        csr_op.wdata.addr = d;
    endfunction

    // Random word address, often close to a stored region boundary.
    function automatic logic [29:0] pick_addr();
        logic [31:0] v;
        v = rnd();
        case (v[1:0])
            2'd0:    pick_addr = v[31:2];
            2'd1:    pick_addr = 30'(v[15:2]);
            default: pick_addr = m_addr[v[7:4]] + 30'(v[10:8]) - 30'd3;
        endcase
    endfunction

    task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Drive, compare at the falling edge, then update the model at the rising edge.
    task automatic run_cycle(input csr_req_t w, input logic [29:0] a0, input logic [29:0] a1,
                             input logic [1:0] mm);
        logic [3:0] locks;
        locks = {w.wdata.cfg[3].lock, w.wdata.cfg[2].lock, w.wdata.cfg[1].lock,
                 w.wdata.cfg[0].lock};
        csr_req      = w;
        check_req[0] = '{addr: a0, m_mode: mm[0]};
        check_req[1] = '{addr: a1, m_mode: mm[1]};
        @(negedge clk);
        compare(64'(csr_rsp), 64'(model_read(w.num)), "csr_rsp");
        compare(64'(check_rsp[0]), 64'(model_check(a0, mm[0])), "check port 0");
        compare(64'(check_rsp[1]), 64'(model_check(a1, mm[1])), "check port 1");
        compare(64'(locking), 64'(|(cfg_writes(w) & locks)), "locking");
        @(posedge clk);
        model_write(w);
        #2;
    endtask

    task automatic end_test(input string name);
        $display("%s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    initial begin
        seed         = 32'h3a0b317a;
        checks       = 0;
        errors       = 0;
        test_errors  = 0;
        csr_req      = '0;
        check_req[0] = '0;
        check_req[1] = '0;
        for (int i = 0; i < depth; i++) begin
            m_cfg[i]  = '0;
            m_addr[i] = '0;
        end
        @(negedge rst);

        // The last four numbers lie past the address registers.
        for (int n = 0; n < t_reset; n++) begin
            r   = rnd();
            num = (n < 4) ? csr_pmpcfg0 + 12'(n) : csr_pmpaddr0 + 12'(n - 4);
            run_cycle(csr_op(1'b0, num, '0), pick_addr(), pick_addr(), r[1:0]);
        end
        end_test("reset state");

        for (int n = 0; n < t_rw / 2; n++) begin
            r   = rnd();
            num = r[4] ? csr_pmpaddr0 + 12'(r[3:0]) : csr_pmpcfg0 + 12'(r[1:0]);
            run_cycle(csr_op(1'b1, num, r[4] ? rnd() : rnd() & 32'h7f7f7f7f),
                      pick_addr(), pick_addr(), 2'b00);
            run_cycle(csr_op(1'b0, num, '0), pick_addr(), pick_addr(), 2'b00);
        end
        end_test("csr write and read-back");

        // Three rounds of ascending regions, new modes, then user checks.
        for (int n = 0; n < t_region; n++) begin
            r = rnd();
            if (n % 50 < 16) begin
                q = csr_op(1'b1, csr_pmpaddr0 + 12'(n % 50), (32'(n % 50) << 10) |
                           (r & 32'h300) | ((32'd1 << r[2:0]) - 32'd1));
            end else if (n % 50 < 20) begin
                q = csr_op(1'b1, csr_pmpcfg0 + 12'(n % 50 - 16),
                           (r & 32'h7f7f7f7f) | ((~r >> 1) & 32'h08080808));
            end else begin
                q = csr_op(1'b0, csr_pmpaddr0, '0);
            end
            run_cycle(q, pick_addr(), pick_addr(), 2'b00);
        end
        end_test("region matching");

        for (int n = 0; n < t_prio; n++) begin
            case (n)
                0, 1, 2: q = csr_op(1'b1, csr_pmpcfg0 + 12'(n + 1), '0);
                3:       q = csr_op(1'b1, csr_pmpaddr0 + 12'd1, 32'h1234);
                4:       q = csr_op(1'b1, csr_pmpaddr0 + 12'd2, 32'h123f);
                5:       q = csr_op(1'b1, csr_pmpaddr0 + 12'd3, 32'h2000);
                6:       q = csr_op(1'b1, csr_pmpcfg0, 32'h0f1e1100);
                default: q = csr_op(1'b0, csr_pmpcfg0, '0);
            endcase
            run_cycle(q, prio_addr[n % 10], prio_addr[(n * 7 + 3) % 10], 2'b00);
        end
        end_test("priority");

        // Lock entries 1 and 3, rewrite them and entry 2, then lock entry 0.
        for (int n = 0; n < t_lock; n++) begin
            r = rnd();
            case (n)
                0:              q = csr_op(1'b1, csr_pmpcfg0, 32'h891e9000);
                1:              q = csr_op(1'b1, csr_pmpcfg0, 32'h0f0f0f0f);
                2:              q = csr_op(1'b1, csr_pmpcfg0, 32'h88888888);
                3, 4, 5, 6:     q = csr_op(1'b1, csr_pmpaddr0 + 12'(n - 2), r);
                7, 8, 9, 10, 11: q = csr_op(1'b0, csr_pmpaddr0 + 12'(n - 7), '0);
                12, 13, 14, 15: q = csr_op(1'b1, csr_pmpcfg0 + 12'd2, r);
                default:        q = csr_op(1'b0, csr_pmpcfg0, '0);
            endcase
            run_cycle(q, prio_addr[n % 10], pick_addr(), 2'b11);
        end
        end_test("locking");

        for (int n = 0; n < t_mix; n++) begin
            r = rnd();
            case (r[1:0])
                2'd0:    num = csr_pmpcfg0 + 12'(r[4:2] % 5);
                2'd1:    num = csr_pmpaddr0 + 12'(r[6:2] % 17);
                2'd2:    num = r[31:20];
                default: num = csr_pmpaddr0 + 12'(r[5:2]);
            endcase
            // Lock bits pass on about one write in eight.
            run_cycle(csr_op(r[8], num, (r[11:9] == 3'd0) ? rnd() : rnd() & 32'h7f7f7f7f),
                      pick_addr(), pick_addr(), r[13:12]);
        end
        end_test("random mix");

        $display("Tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
design/pmp_pkg.sv
design/pmp_csr_file.sv
design/pmp_region_match.sv
design/pmp_check_port.sv
design/pmp_unit.sv
verif/pmp_clock_gen.sv
verif/pmp_unit_tb.sv
